//--- logic/aluUnit.sv
// Datapath ALU
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  wire  wiscPkg::wordT  inA,
   input  wire  wiscPkg::wordT  inB,
   input  wire                  cin,
   input  wire                  invA,
   input  wire                  invB,
   input  wire                  shiftOp,  // shift/rotate group
   input  wire                  btrOp,    // bit reverse of A
   input  wire  wiscPkg::aluOpT aluOp,
   output wiscPkg::wordT        result,
   output logic                 zero,
   output logic                 sign,
   output logic                 carry
);

   wiscPkg::wordT opA;
   wiscPkg::wordT opB;
   wiscPkg::wordT arith;
   wiscPkg::wordT shifted;
   wiscPkg::wordT reversed;
   logic [16:0]   sum;                    // carry in bit 16
   logic [31:0]   rotL;
   logic [31:0]   rotR;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;
   assign sum = {1'b0, opA} + {1'b0, opB} + {16'b0, cin};

   // doubled word makes the rotates plain shifts
   assign rotL = {inA, inA} << inB[3:0];
   assign rotR = {inA, inA} >> inB[3:0];

   always_comb begin
      case (aluOp)
         2'b10:   arith = opA ^ opB;
         2'b11:   arith = opA & opB;      // andn via invB
         default: arith = sum[15:0];      // add and sub
      endcase
   end

   always_comb begin
      case (aluOp)
         2'b00:   shifted = rotL[31:16];
         2'b01:   shifted = inA << inB[3:0];
         2'b10:   shifted = rotR[15:0];
         default: shifted = inA >> inB[3:0];  // logical
      endcase
   end

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         reversed[i] = inA[15 - i];
      end
   end

   assign result = btrOp ? reversed : (shiftOp ? shifted : arith);

   // flags always from the adder
   assign zero  = (sum[15:0] == 16'h0000);
   assign sign  = sum[15];
   assign carry = sum[16];

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  wire  wiscPkg::wordT instruction,
   output logic                regWrt,      // register writeback
   output logic                memWrt,      // data memory store
   output logic                cin,         // adder carry in
   output logic                invA,        // invert operand A
   output logic                invB,        // invert operand B
   output logic                immSrc,      // pc offset from imm11
   output logic                zeroSel,     // zero extend imm5
   output logic                stuSel,      // store data from register B
   output logic                setSel,      // write condition bit
   output logic                jalSel,      // link pc+2 instead of slbi value
   output logic                aluPc,       // jump target from alu
   output logic                err,         // opcode not decoded
   output logic [1:0]          wbDataSel,
   output logic [1:0]          bSrc,
   output logic [1:0]          regDestSel,
   output wiscPkg::condT       brchSig,
   output wiscPkg::aluOpT      aluOp
);

   wiscPkg::opcodeT opcode;

   assign opcode = instruction[15:11];

   always_comb begin
      regWrt     = 1'b0;
      memWrt     = 1'b0;
      cin        = 1'b0;
      invA       = 1'b0;
      invB       = 1'b0;
      immSrc     = 1'b0;
      zeroSel    = 1'b0;
      stuSel     = 1'b0;
      setSel     = 1'b0;
      jalSel     = 1'b0;
      aluPc      = 1'b0;
      err        = 1'b0;
      wbDataSel  = wiscPkg::WB_ALU;
      bSrc       = wiscPkg::B_REG;
      regDestSel = wiscPkg::DST_RS;
      brchSig    = wiscPkg::COND_NEVER;
      aluOp      = 2'b00;                               // plain add
      case (opcode)
         wiscPkg::OP_HALT, wiscPkg::OP_NOP, wiscPkg::OP_SIIC, wiscPkg::OP_RTI: begin
            // no state change here, halt handled by core
         end
         wiscPkg::OP_ADDI, wiscPkg::OP_SUBI: begin
            regWrt     = 1'b1;
            bSrc       = wiscPkg::B_IMM;                // sign extended imm5
            regDestSel = wiscPkg::DST_RD;
            aluOp      = instruction[12:11];
            cin        = (opcode == wiscPkg::OP_SUBI);  // imm - rs
            invA       = (opcode == wiscPkg::OP_SUBI);
         end
         wiscPkg::OP_XORI, wiscPkg::OP_ANDNI: begin
            regWrt     = 1'b1;
            bSrc       = wiscPkg::B_IMM;
            zeroSel    = 1'b1;
            regDestSel = wiscPkg::DST_RD;
            aluOp      = instruction[12:11];
            invB       = (opcode == wiscPkg::OP_ANDNI); // rs & ~imm
         end
         wiscPkg::OP_ROLI, wiscPkg::OP_SLLI, wiscPkg::OP_RORI, wiscPkg::OP_SRLI: begin
            regWrt     = 1'b1;
            bSrc       = wiscPkg::B_IMM;
            zeroSel    = 1'b1;                          // shift count, never negative
            regDestSel = wiscPkg::DST_RD;
            aluOp      = instruction[12:11];
         end
         wiscPkg::OP_ST: begin
            memWrt = 1'b1;
            stuSel = 1'b1;                              // store rd field register
            bSrc   = wiscPkg::B_IMM;                    // address rs + imm5
         end
         wiscPkg::OP_LD: begin
            regWrt     = 1'b1;
            wbDataSel  = wiscPkg::WB_MEM;
            bSrc       = wiscPkg::B_IMM;
            regDestSel = wiscPkg::DST_RD;
         end
         wiscPkg::OP_STU: begin
            memWrt     = 1'b1;
            stuSel     = 1'b1;
            regWrt     = 1'b1;                          // base update, rs <- rs + imm
            bSrc       = wiscPkg::B_IMM;
            regDestSel = wiscPkg::DST_RS;
         end
         wiscPkg::OP_BTR: begin
            regWrt     = 1'b1;
            regDestSel = wiscPkg::DST_RDR;
         end
         wiscPkg::OP_ALU_R: begin
            regWrt     = 1'b1;
            regDestSel = wiscPkg::DST_RDR;
            aluOp      = instruction[1:0];
            cin        = (instruction[1:0] == 2'b01);   // sub gives rt - rs
            invA       = (instruction[1:0] == 2'b01);
            invB       = (instruction[1:0] == 2'b11);   // andn
         end
         wiscPkg::OP_SHIFT_R: begin
            regWrt     = 1'b1;
            regDestSel = wiscPkg::DST_RDR;
            aluOp      = instruction[1:0];
         end
         wiscPkg::OP_SEQ, wiscPkg::OP_SLT, wiscPkg::OP_SLE: begin
            regWrt     = 1'b1;
            setSel     = 1'b1;
            regDestSel = wiscPkg::DST_RDR;
            invB       = 1'b1;                          // flags of rs - rt
            cin        = 1'b1;
            if (opcode == wiscPkg::OP_SEQ)
               brchSig = wiscPkg::COND_ZERO;
            else if (opcode == wiscPkg::OP_SLT)
               brchSig = wiscPkg::COND_SIGN;
            else
               brchSig = wiscPkg::COND_ZSIGN;
         end
         wiscPkg::OP_SCO: begin
            regWrt     = 1'b1;
            setSel     = 1'b1;
            regDestSel = wiscPkg::DST_RDR;
            brchSig    = wiscPkg::COND_CARRY;           // carry out of rs + rt
         end
         wiscPkg::OP_BEQZ: begin
            bSrc    = wiscPkg::B_ZERO;                  // flags of rs alone
            brchSig = wiscPkg::COND_ZERO;
         end
         wiscPkg::OP_BNEZ: begin
            bSrc    = wiscPkg::B_ZERO;
            brchSig = wiscPkg::COND_NZERO;
         end
         wiscPkg::OP_BLTZ: begin
            bSrc    = wiscPkg::B_ZERO;
            brchSig = wiscPkg::COND_SIGN;
         end
         wiscPkg::OP_BGEZ: begin
            bSrc    = wiscPkg::B_ZERO;
            brchSig = wiscPkg::COND_NSIGN;
         end
         wiscPkg::OP_LBI: begin
            regWrt    = 1'b1;
            wbDataSel = wiscPkg::WB_IMM8;
         end
         wiscPkg::OP_SLBI: begin
            regWrt    = 1'b1;
            wbDataSel = wiscPkg::WB_PC2;                // jalSel low picks slbi value
         end
         wiscPkg::OP_J: begin
            immSrc  = 1'b1;
            brchSig = wiscPkg::COND_ALWAYS;
         end
         wiscPkg::OP_JR: begin
            aluPc   = 1'b1;                             // target is rs
            bSrc    = wiscPkg::B_ZERO;
            brchSig = wiscPkg::COND_ALWAYS;
         end
         wiscPkg::OP_JAL: begin
            immSrc     = 1'b1;
            brchSig    = wiscPkg::COND_ALWAYS;
            regWrt     = 1'b1;
            jalSel     = 1'b1;
            wbDataSel  = wiscPkg::WB_PC2;
            regDestSel = wiscPkg::DST_R7;
         end
         wiscPkg::OP_JALR: begin
            aluPc      = 1'b1;
            bSrc       = wiscPkg::B_ZERO;
            brchSig    = wiscPkg::COND_ALWAYS;
            regWrt     = 1'b1;
            jalSel     = 1'b1;
            wbDataSel  = wiscPkg::WB_PC2;
            regDestSel = wiscPkg::DST_R7;
         end
         default: begin
            err = 1'b1;                                 // all enables stay low
         end
      endcase
   end

   // a faulting opcode must never reach the memory
   always_comb begin
      assert (!(memWrt && err)) else $error("controlUnit: store decoded with err");
   end

endmodule

`default_nettype wire

//--- logic/dataMem.sv
// Word data memory
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
   parameter int DMEM_ADDR_W = 6           // word address bits
) (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 wrEn,
   input  wire  wiscPkg::wordT addr,       // byte address
   input  wire  wiscPkg::wordT wrData,
   output wiscPkg::wordT       rdData
);

   localparam int DEPTH = 1 << DMEM_ADDR_W;

   wiscPkg::wordT          mem [DEPTH];
   logic [DMEM_ADDR_W-1:0] wordIdx;

   assign wordIdx = addr[DMEM_ADDR_W:1];   // drop byte bit, upper bits alias

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wrEn) begin
         mem[wordIdx] <= wrData;
      end
   end

   assign rdData = mem[wordIdx];           // async read

endmodule

`default_nettype wire

//--- logic/pcUnit.sv
// Program counter and branch logic
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 advance,      // accepted fetch beat
   input  wire  wiscPkg::condT brchSig,
   input  wire                 zero,
   input  wire                 sign,
   input  wire                 carry,
   input  wire                 immSrc,
   input  wire                 aluPc,
   input  wire  wiscPkg::wordT instruction,
   input  wire  wiscPkg::wordT aluResult,
   output wiscPkg::wordT       pc,
   output wiscPkg::wordT       pcPlus2,
   output wiscPkg::wordT       nextPc,
   output logic                condTrue
);

   wiscPkg::wordT brOff;
   wiscPkg::wordT jmpOff;
   wiscPkg::wordT target;
   logic          flowCtl;

   assign pcPlus2 = pc + 16'd2;
   assign brOff   = {{8{instruction[7]}}, instruction[7:0]};
   assign jmpOff  = {{5{instruction[10]}}, instruction[10:0]};

   // only jumps (001xx) and branches (011xx) redirect, set forms reuse the condition
   assign flowCtl = !instruction[15] && instruction[13];

   always_comb begin
      case (brchSig)
         wiscPkg::COND_CARRY:  condTrue = carry;
         wiscPkg::COND_ZERO:   condTrue = zero;
         wiscPkg::COND_NSIGN:  condTrue = !sign;
         wiscPkg::COND_SIGN:   condTrue = sign;
         wiscPkg::COND_NZERO:  condTrue = !zero;
         wiscPkg::COND_ZSIGN:  condTrue = zero || sign;
         wiscPkg::COND_ALWAYS: condTrue = 1'b1;
         default:              condTrue = 1'b0;
      endcase
   end

   assign target = aluPc ? aluResult : pcPlus2 + (immSrc ? jmpOff : brOff);
   assign nextPc = (flowCtl && condTrue) ? target : pcPlus2;

   always_ff @(posedge clk) begin
      if (rst)
         pc <= '0;
      else if (advance)
         pc <= nextPc;
   end

   // halfword instructions, so fetch address keeps bit 0 clear
   assert property (@(posedge clk) disable iff (rst) !pc[0])
      else $error("pcUnit: odd pc %h", pc);

endmodule

`default_nettype wire

//--- logic/regFile.sv
// Eight entry register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire                   clk,
   input  wire                   rst,
   input  wire  wiscPkg::regIdxT rdIdxA,
   input  wire  wiscPkg::regIdxT rdIdxB,
   input  wire  wiscPkg::regIdxT wrIdx,
   input  wire                   wrEn,
   input  wire  wiscPkg::wordT   wrData,
   output wiscPkg::wordT         rdDataA,
   output wiscPkg::wordT         rdDataB
);

   wiscPkg::wordT regs [8];   // r0 is an ordinary register

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // no bypass, same-cycle read sees the old value
   assign rdDataA = regs[rdIdxA];
   assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

//--- logic/wiscCore.sv
// Single-cycle WISC core
`timescale 1ns/1ps
`default_nettype none

module wiscCore #(
   parameter int DMEM_ADDR_W = 6
) (
   input  wire                   clk,
   input  wire                   rst,
   output wiscPkg::wordT         fetchPc,
   input  wire                   instrValid,
   input  wire  wiscPkg::wordT   instruction,
   output logic                  instrReady,
   output logic                  retValid,
   output wiscPkg::wordT         retPc,
   output wiscPkg::wordT         retNextPc,
   output logic                  retWbEn,
   output wiscPkg::regIdxT       retWbReg,
   output wiscPkg::wordT         retWbData,
   output logic                  retErr,
   output logic                  halted
);

   wiscPkg::coreStateT state;
   wiscPkg::opcodeT    opcode;
   wiscPkg::condT      brchSig;
   wiscPkg::aluOpT     aluOp;
   wiscPkg::regIdxT    wrIdx;
   wiscPkg::wordT      rdDataA, rdDataB, memRdData, memWrData;
   wiscPkg::wordT      opB, imm5, slbiVal, wbData;
   wiscPkg::wordT      aluResult, pcPlus2, nextPc;
   logic [1:0]         wbDataSel, bSrc, regDestSel;
   logic regWrt, memWrt, cin, invA, invB, immSrc, zeroSel, stuSel;
   logic setSel, jalSel, aluPc, err;
   logic zero, sign, carry, condTrue;
   logic accept, shiftOp, btrOp;

   assign opcode     = instruction[15:11];
   assign instrReady = (state == wiscPkg::CORE_RUN);
   assign halted     = (state == wiscPkg::CORE_HALTED);
   assign accept     = instrValid && instrReady;   // the one beat that commits

   // alu sub-function groups not covered by aluOp
   assign shiftOp = (opcode == wiscPkg::OP_SHIFT_R) || (opcode[4:2] == 3'b101);
   assign btrOp   = (opcode == wiscPkg::OP_BTR);

   controlUnit ctrl0 (
      .instruction(instruction), .regWrt(regWrt), .memWrt(memWrt), .cin(cin),
      .invA(invA), .invB(invB), .immSrc(immSrc), .zeroSel(zeroSel), .stuSel(stuSel),
      .setSel(setSel), .jalSel(jalSel), .aluPc(aluPc), .err(err),
      .wbDataSel(wbDataSel), .bSrc(bSrc), .regDestSel(regDestSel),
      .brchSig(brchSig), .aluOp(aluOp)
   );

   regFile rf0 (
      .clk(clk), .rst(rst), .rdIdxA(instruction[10:8]), .rdIdxB(instruction[7:5]),
      .wrIdx(wrIdx), .wrEn(regWrt && accept), .wrData(wbData),
      .rdDataA(rdDataA), .rdDataB(rdDataB)
   );

   assign imm5 = zeroSel ? {11'b0, instruction[4:0]} : {{11{instruction[4]}}, instruction[4:0]};

   always_comb begin
      case (bSrc)
         wiscPkg::B_REG: opB = rdDataB;
         wiscPkg::B_IMM: opB = imm5;
         default:        opB = '0;   // branch tests and register jumps
      endcase
   end

   aluUnit alu0 (
      .inA(rdDataA), .inB(opB), .cin(cin), .invA(invA), .invB(invB),
      .shiftOp(shiftOp), .btrOp(btrOp), .aluOp(aluOp),
      .result(aluResult), .zero(zero), .sign(sign), .carry(carry)
   );

   pcUnit pc0 (
      .clk(clk), .rst(rst), .advance(accept), .brchSig(brchSig),
      .zero(zero), .sign(sign), .carry(carry), .immSrc(immSrc), .aluPc(aluPc),
      .instruction(instruction), .aluResult(aluResult),
      .pc(fetchPc), .pcPlus2(pcPlus2), .nextPc(nextPc), .condTrue(condTrue)
   );

   assign memWrData = stuSel ? rdDataB : aluResult;

   dataMem #(.DMEM_ADDR_W(DMEM_ADDR_W)) dmem0 (
      .clk(clk), .rst(rst), .wrEn(memWrt && accept), .addr(aluResult),
      .wrData(memWrData), .rdData(memRdData)
   );

   assign slbiVal = {rdDataA[7:0], instruction[7:0]};   // (rs << 8) | zext imm8

   always_comb begin
      case (wbDataSel)
         wiscPkg::WB_PC2: wbData = jalSel ? pcPlus2 : slbiVal;
         wiscPkg::WB_MEM: wbData = memRdData;
         wiscPkg::WB_ALU: wbData = setSel ? {15'b0, condTrue} : aluResult;
         default:         wbData = {{8{instruction[7]}}, instruction[7:0]};   // lbi
      endcase
   end

   always_comb begin
      case (regDestSel)
         wiscPkg::DST_RS:  wrIdx = instruction[10:8];
         wiscPkg::DST_RD:  wrIdx = instruction[7:5];
         wiscPkg::DST_RDR: wrIdx = instruction[4:2];
         default:          wrIdx = 3'd7;   // link
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state <= wiscPkg::CORE_RUN;
      else if (accept && opcode == wiscPkg::OP_HALT)
         state <= wiscPkg::CORE_HALTED;   // sticky until reset
   end

   always_ff @(posedge clk) begin
      if (rst)
         retValid <= 1'b0;
      else
         retValid <= accept;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         retPc     <= fetchPc;
         retNextPc <= nextPc;
         retWbEn   <= regWrt;
         retWbReg  <= wrIdx;
         retWbData <= wbData;
         retErr    <= err;
      end
   end

   // one record per accepted instruction, pc already moved to the recorded next pc
   assert property (@(posedge clk) disable iff (rst)
                    retValid |-> $past(accept) && (fetchPc == retNextPc))
      else $error("wiscCore: retire without accepted fetch or pc not updated");

endmodule

`default_nettype wire

//--- logic/wiscPkg.sv
// WISC core shared definitions
`default_nettype none

package wiscPkg;

   typedef logic [15:0] wordT;    // data, address and instruction word
   typedef logic [2:0]  regIdxT;  // register number
   typedef logic [4:0]  opcodeT;  // instruction bits 15:11
   typedef logic [2:0]  condT;    // flag condition code
   typedef logic [1:0]  aluOpT;   // add/sub/xor/andn or rol/sll/ror/srl

   typedef enum logic {CORE_RUN, CORE_HALTED} coreStateT;

   // major opcodes
   localparam opcodeT OP_HALT    = 5'b00000;
   localparam opcodeT OP_NOP     = 5'b00001;
   localparam opcodeT OP_SIIC    = 5'b00010;  // no exceptions, retires as nop
   localparam opcodeT OP_RTI     = 5'b00011;  // likewise
   localparam opcodeT OP_J       = 5'b00100;
   localparam opcodeT OP_JR      = 5'b00101;
   localparam opcodeT OP_JAL     = 5'b00110;
   localparam opcodeT OP_JALR    = 5'b00111;
   localparam opcodeT OP_ADDI    = 5'b01000;
   localparam opcodeT OP_SUBI    = 5'b01001;
   localparam opcodeT OP_XORI    = 5'b01010;
   localparam opcodeT OP_ANDNI   = 5'b01011;
   localparam opcodeT OP_BEQZ    = 5'b01100;
   localparam opcodeT OP_BNEZ    = 5'b01101;
   localparam opcodeT OP_BLTZ    = 5'b01110;
   localparam opcodeT OP_BGEZ    = 5'b01111;
   localparam opcodeT OP_ST      = 5'b10000;
   localparam opcodeT OP_LD      = 5'b10001;
   localparam opcodeT OP_SLBI    = 5'b10010;
   localparam opcodeT OP_STU     = 5'b10011;
   localparam opcodeT OP_ROLI    = 5'b10100;
   localparam opcodeT OP_SLLI    = 5'b10101;
   localparam opcodeT OP_RORI    = 5'b10110;
   localparam opcodeT OP_SRLI    = 5'b10111;
   localparam opcodeT OP_LBI     = 5'b11000;
   localparam opcodeT OP_BTR     = 5'b11001;
   localparam opcodeT OP_SHIFT_R = 5'b11010;  // rol, sll, ror, srl by bits 1:0
   localparam opcodeT OP_ALU_R   = 5'b11011;  // add, sub, xor, andn by bits 1:0
   localparam opcodeT OP_SEQ     = 5'b11100;
   localparam opcodeT OP_SLT     = 5'b11101;
   localparam opcodeT OP_SLE     = 5'b11110;
   localparam opcodeT OP_SCO     = 5'b11111;

   // writeback source
   localparam logic [1:0] WB_PC2  = 2'b00;  // pc+2 for links, else slbi value
   localparam logic [1:0] WB_MEM  = 2'b01;
   localparam logic [1:0] WB_ALU  = 2'b10;  // alu result or set bit
   localparam logic [1:0] WB_IMM8 = 2'b11;

   // destination register field
   localparam logic [1:0] DST_RS  = 2'b00;  // bits 10:8
   localparam logic [1:0] DST_RD  = 2'b01;  // bits 7:5, I-format
   localparam logic [1:0] DST_RDR = 2'b10;  // bits 4:2, R-format
   localparam logic [1:0] DST_R7  = 2'b11;  // link register

   // alu operand B source
   localparam logic [1:0] B_REG  = 2'b00;
   localparam logic [1:0] B_IMM  = 2'b01;
   localparam logic [1:0] B_ZERO = 2'b11;

   // condition codes
   localparam condT COND_NEVER  = 3'b000;
   localparam condT COND_CARRY  = 3'b001;
   localparam condT COND_ZERO   = 3'b010;
   localparam condT COND_NSIGN  = 3'b011;  // greater or equal
   localparam condT COND_SIGN   = 3'b100;
   localparam condT COND_NZERO  = 3'b101;
   localparam condT COND_ZSIGN  = 3'b110;
   localparam condT COND_ALWAYS = 3'b111;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module wiscCoreTb -o wiscCoreSim
./obj_dir/wiscCoreSim | tee sim.log
if grep -qx "Regression passed" sim.log; then
   echo "simulation PASS"
   exit 0
fi
echo "simulation FAIL"
exit 1

//--- tests/wiscCoreTb.sv
// WISC core testbench
`timescale 1ns/1ps
`default_nettype none

module wiscCoreTb;

   localparam int MAX_ROWS    = 64;
   localparam int WAIT_LIMIT  = 50;    // cycles per bounded wait
   localparam int HALT_WINDOW = 20;    // cycles watched after halt

   logic            clk;
   logic            rst;
   logic            instrValid;
   wiscPkg::wordT   instruction;
   wiscPkg::wordT   fetchPc;
   logic            instrReady;
   logic            retValid;
   wiscPkg::wordT   retPc;
   wiscPkg::wordT   retNextPc;
   logic            retWbEn;
   wiscPkg::regIdxT retWbReg;
   wiscPkg::wordT   retWbData;
   logic            retErr;
   logic            halted;

   // stimulus table, one row per fetched instruction
   wiscPkg::wordT   tInstr  [MAX_ROWS];
   wiscPkg::wordT   tNext   [MAX_ROWS];   // expected retNextPc
   logic            tWbEn   [MAX_ROWS];
   wiscPkg::regIdxT tWbReg  [MAX_ROWS];
   wiscPkg::wordT   tWbData [MAX_ROWS];
   logic            tErr    [MAX_ROWS];
   int              nRows;

   int              errCount;
   int              checkCount;
   int              timeoutCount;
   logic            stopRun;               // a wait ran out
   integer          seed;
   wiscPkg::wordT   expPc;                 // pc of the row in flight

   wiscCore #(.DMEM_ADDR_W(6)) dut0 (
      .clk(clk), .rst(rst), .fetchPc(fetchPc), .instrValid(instrValid),
      .instruction(instruction), .instrReady(instrReady), .retValid(retValid),
      .retPc(retPc), .retNextPc(retNextPc), .retWbEn(retWbEn), .retWbReg(retWbReg),
      .retWbData(retWbData), .retErr(retErr), .halted(halted)
   );

   always #5 clk = ~clk;                   // 10 ns period

   // I-format, rs rd imm5
   function automatic wiscPkg::wordT encRI(wiscPkg::opcodeT op, int rs, int rd, int imm);
      return {op, rs[2:0], rd[2:0], imm[4:0]};
   endfunction

   // R-format, rs rt rd and function bits
   function automatic wiscPkg::wordT encRR(wiscPkg::opcodeT op, int rs, int rt, int rd,
                                           int fn);
      return {op, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
   endfunction

   function automatic wiscPkg::wordT encIm8(wiscPkg::opcodeT op, int rs, int imm);
      return {op, rs[2:0], imm[7:0]};
   endfunction

   function automatic wiscPkg::wordT encJmp(wiscPkg::opcodeT op, int off);
      return {op, off[10:0]};                // 11-bit pc offset
   endfunction

   task automatic addRow(wiscPkg::wordT instr, int nxt, int wbEn, int wbReg, int wbData,
                         int err);
      tInstr[nRows]  = instr;
      tNext[nRows]   = nxt[15:0];
      tWbEn[nRows]   = wbEn[0];
      tWbReg[nRows]  = wbReg[2:0];
      tWbData[nRows] = wbData[15:0];
      tErr[nRows]    = err[0];
      nRows++;
   endtask

   task automatic checkValue(string name, wiscPkg::wordT got, wiscPkg::wordT exp);
      checkCount++;
      assert (got === exp) else begin
         $display("MISMATCH %s got %h expected %h at pc %h", name, got, exp, expPc);
         errCount++;
      end
   endtask

   task automatic waitReady();
      int cnt;
      cnt = 0;
      while (!instrReady && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!instrReady) begin
         $display("timeout: instrReady stayed low for %0d cycles at pc %h", WAIT_LIMIT, expPc);
         timeoutCount++;
         stopRun = 1'b1;
      end
   endtask

   task automatic waitRetire();
      int cnt;
      cnt = 0;
      while (!retValid && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!retValid) begin
         $display("timeout: no retire record for the instruction at pc %h", expPc);
         timeoutCount++;
         stopRun = 1'b1;
      end
   endtask

   task automatic loadTable();
      // known register values first
      addRow(encIm8(wiscPkg::OP_LBI, 1, 'h12), 'h02, 1, 1, 'h0012, 0);
      addRow(encIm8(wiscPkg::OP_LBI, 2, 'h85), 'h04, 1, 2, 'hFF85, 0);     // sign extended
      addRow(encIm8(wiscPkg::OP_SLBI, 1, 'h34), 'h06, 1, 1, 'h1234, 0);
      addRow(encIm8(wiscPkg::OP_LBI, 3, 'h05), 'h08, 1, 3, 'h0005, 0);
      addRow(encIm8(wiscPkg::OP_LBI, 4, 'hF0), 'h0A, 1, 4, 'hFFF0, 0);
      // immediate alu forms
      addRow(encRI(wiscPkg::OP_ADDI, 1, 5, -3), 'h0C, 1, 5, 'h1231, 0);
      addRow(encRI(wiscPkg::OP_SUBI, 3, 6, 2), 'h0E, 1, 6, 'hFFFD, 0);    // imm minus rs
      addRow(encRI(wiscPkg::OP_XORI, 1, 5, 'h1F), 'h10, 1, 5, 'h122B, 0);
      addRow(encRI(wiscPkg::OP_ANDNI, 1, 6, 'h0F), 'h12, 1, 6, 'h1230, 0);
      addRow(encRI(wiscPkg::OP_ROLI, 1, 5, 4), 'h14, 1, 5, 'h2341, 0);
      addRow(encRI(wiscPkg::OP_SLLI, 1, 6, 4), 'h16, 1, 6, 'h2340, 0);
      addRow(encRI(wiscPkg::OP_RORI, 1, 5, 4), 'h18, 1, 5, 'h4123, 0);
      addRow(encRI(wiscPkg::OP_SRLI, 1, 6, 4), 'h1A, 1, 6, 'h0123, 0);
      // register forms
      addRow(encRR(wiscPkg::OP_ALU_R, 1, 3, 5, 0), 'h1C, 1, 5, 'h1239, 0);
      addRow(encRR(wiscPkg::OP_ALU_R, 3, 1, 6, 1), 'h1E, 1, 6, 'h122F, 0);  // rt minus rs
      addRow(encRR(wiscPkg::OP_ALU_R, 1, 2, 5, 2), 'h20, 1, 5, 'hEDB1, 0);
      addRow(encRR(wiscPkg::OP_ALU_R, 1, 2, 6, 3), 'h22, 1, 6, 'h0030, 0);
      addRow(encRR(wiscPkg::OP_SHIFT_R, 1, 3, 5, 0), 'h24, 1, 5, 'h4682, 0);
      addRow(encRR(wiscPkg::OP_SHIFT_R, 1, 3, 6, 1), 'h26, 1, 6, 'h4680, 0);
      addRow(encRR(wiscPkg::OP_SHIFT_R, 1, 3, 5, 2), 'h28, 1, 5, 'hA091, 0);
      addRow(encRR(wiscPkg::OP_SHIFT_R, 1, 3, 6, 3), 'h2A, 1, 6, 'h0091, 0);
      addRow(encRR(wiscPkg::OP_BTR, 1, 0, 5, 0), 'h2C, 1, 5, 'h2C48, 0);    // bit reverse
      // set forms
      addRow(encRR(wiscPkg::OP_SEQ, 1, 1, 5, 0), 'h2E, 1, 5, 'h0001, 0);
      addRow(encRR(wiscPkg::OP_SEQ, 1, 3, 6, 0), 'h30, 1, 6, 'h0000, 0);
      addRow(encRR(wiscPkg::OP_SLT, 3, 1, 5, 0), 'h32, 1, 5, 'h0001, 0);
      addRow(encRR(wiscPkg::OP_SLT, 1, 3, 6, 0), 'h34, 1, 6, 'h0000, 0);
      addRow(encRR(wiscPkg::OP_SLE, 3, 3, 5, 0), 'h36, 1, 5, 'h0001, 0);
      addRow(encRR(wiscPkg::OP_SLE, 1, 3, 6, 0), 'h38, 1, 6, 'h0000, 0);
      addRow(encRR(wiscPkg::OP_SCO, 2, 4, 5, 0), 'h3A, 1, 5, 'h0001, 0);    // carry out
      addRow(encRR(wiscPkg::OP_SCO, 1, 3, 6, 0), 'h3C, 1, 6, 'h0000, 0);
      // memory, byte address 8 then 10
      addRow(encRI(wiscPkg::OP_ST, 3, 1, 3), 'h3E, 0, 0, 'h0000, 0);
      addRow(encRI(wiscPkg::OP_LD, 3, 5, 3), 'h40, 1, 5, 'h1234, 0);
      addRow(encRI(wiscPkg::OP_STU, 3, 2, 5), 'h42, 1, 3, 'h000A, 0);      // base update
      addRow(encRI(wiscPkg::OP_LD, 3, 6, 0), 'h44, 1, 6, 'hFF85, 0);
      addRow(encRI(wiscPkg::OP_LD, 0, 5, 2), 'h46, 1, 5, 'h0000, 0);       // untouched word
      // branches, taken and not taken
      addRow(encIm8(wiscPkg::OP_BEQZ, 5, 4), 'h4C, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BEQZ, 1, 'h10), 'h4E, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BNEZ, 1, 2), 'h52, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BNEZ, 0, 'h20), 'h54, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BLTZ, 2, -4), 'h52, 0, 0, 'h0000, 0);      // backward
      addRow(encIm8(wiscPkg::OP_BLTZ, 1, 'h40), 'h54, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BGEZ, 1, 6), 'h5C, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_BGEZ, 4, 8), 'h5E, 0, 0, 'h0000, 0);
      // jumps
      addRow(encJmp(wiscPkg::OP_J, 'h10), 'h70, 0, 0, 'h0000, 0);
      addRow(encJmp(wiscPkg::OP_J, -16), 'h62, 0, 0, 'h0000, 0);
      addRow(encJmp(wiscPkg::OP_JAL, 'h20), 'h84, 1, 7, 'h0064, 0);         // link pc+2
      addRow(encIm8(wiscPkg::OP_JR, 1, 0), 'h1234, 0, 0, 'h0000, 0);
      addRow(encIm8(wiscPkg::OP_JALR, 3, 0), 'h000A, 1, 7, 'h1236, 0);
      // no-op group writes nothing
      addRow(encJmp(wiscPkg::OP_NOP, 0), 'h0C, 0, 0, 'h0000, 0);
      addRow(encJmp(wiscPkg::OP_SIIC, 0), 'h0E, 0, 0, 'h0000, 0);
      addRow(encJmp(wiscPkg::OP_RTI, 0), 'h10, 0, 0, 'h0000, 0);
      // r0 is an ordinary register
      addRow(encRI(wiscPkg::OP_ADDI, 1, 0, 1), 'h12, 1, 0, 'h1235, 0);
      addRow(encRR(wiscPkg::OP_ALU_R, 0, 0, 5, 0), 'h14, 1, 5, 'h246A, 0);
      addRow(encJmp(wiscPkg::OP_HALT, 0), 'h16, 0, 0, 'h0000, 0);          // must stay last
   endtask

   task automatic runRow(int i);
      int gap;
      waitReady();
      if (!stopRun) begin
         checkValue("fetchPc", fetchPc, expPc);
         instruction = tInstr[i];
         instrValid  = 1'b1;
         @(negedge clk);                     // taken on the edge just passed
         instrValid = 1'b0;
         waitRetire();
      end
      if (!stopRun) begin
         checkValue("retPc", retPc, expPc);
         checkValue("retNextPc", retNextPc, tNext[i]);
         checkValue("retWbEn", {15'b0, retWbEn}, {15'b0, tWbEn[i]});
         checkValue("retErr", {15'b0, retErr}, {15'b0, tErr[i]});
         if (tWbEn[i]) begin                 // reg and data only mean something with wbEn
            checkValue("retWbReg", {13'b0, retWbReg}, {13'b0, tWbReg[i]});
            checkValue("retWbData", retWbData, tWbData[i]);
         end
         expPc = tNext[i];
         gap = $unsigned($random(seed)) % 4;
         for (int g = 0; g < gap; g++) begin
            @(negedge clk);
            checkValue("retValid", {15'b0, retValid}, 16'h0000);   // idle, no record
         end
      end
   endtask

   task automatic checkHalt();
      checkValue("halted", {15'b0, halted}, 16'h0001);
      checkValue("instrReady", {15'b0, instrReady}, 16'h0000);
      instruction = encJmp(wiscPkg::OP_NOP, 0);
      instrValid  = 1'b1;                    // offered, never accepted
      for (int k = 0; k < HALT_WINDOW; k++) begin
         @(negedge clk);
         checkValue("retValid", {15'b0, retValid}, 16'h0000);
      end
      checkValue("halted", {15'b0, halted}, 16'h0001);
      checkValue("fetchPc", fetchPc, expPc); // pc frozen after halt
      instrValid = 1'b0;
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      instrValid   = 1'b0;
      instruction  = '0;
      seed         = 37703;
      nRows        = 0;
      errCount     = 0;
      checkCount   = 0;
      timeoutCount = 0;
      stopRun      = 1'b0;
      expPc        = '0;
      loadTable();
      repeat (4) @(negedge clk);             // 4 reset cycles
      rst = 1'b0;
      checkValue("retValid", {15'b0, retValid}, 16'h0000);
      checkValue("halted", {15'b0, halted}, 16'h0000);
      checkValue("instrReady", {15'b0, instrReady}, 16'h0001);
      checkValue("fetchPc", fetchPc, 16'h0000);
      for (int i = 0; i < nRows && !stopRun; i++) begin
         runRow(i);
      end
      if (!stopRun) begin
         checkHalt();
      end
      $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount, timeoutCount);
      if (errCount == 0 && timeoutCount == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
logic/wiscPkg.sv
logic/controlUnit.sv
logic/aluUnit.sv
logic/pcUnit.sv
logic/regFile.sv
logic/dataMem.sv
logic/wiscCore.sv
tests/wiscCoreTb.sv
